//--- source/tile_params.svh
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// Bus widths
`define WB_ADR_W 32
`define WB_DAT_W 32
`define WB_SEL_W 4

`define NUM_MASTERS 2

// Memory depths in words
`define SRAM_WORDS 1024
`define BOOT_WORDS 16

// Top address nibble per region
`define REGION_W    4
`define REGION_SRAM 4'h0
`define REGION_EXT  4'he
`define REGION_BOOT 4'hf

`endif

//--- source/wb_pkg.sv
`include "tile_params.svh"

package wb_pkg;

  // Master to slave, classic single transfer
  typedef struct packed {
    logic [`WB_ADR_W-1:0] adr;
    logic [`WB_DAT_W-1:0] dat;
    logic [`WB_SEL_W-1:0] sel;
    logic                 we;
    logic                 cyc;
    logic                 stb;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic [`WB_DAT_W-1:0] dat;
    logic                 ack;
    logic                 err;
  } wb_rsp_t;

endpackage

//--- source/tile_pkg.sv
`include "tile_params.svh"

package tile_pkg;

  typedef enum logic [1:0] {
    SLV_SRAM = 2'd0,
    SLV_BOOT = 2'd1,
    SLV_EXT  = 2'd2,
    SLV_NONE = 2'd3
  } slave_sel_t;

  // Boot code, jumps into local memory
  parameter logic [`WB_DAT_W-1:0] BOOT_IMAGE [`BOOT_WORDS] = '{
    32'h18000000,
    32'h18200000,
    32'ha8210000,
    32'h18400000,
    32'ha8420100,
    32'h18600000,
    32'ha8630004,
    32'hd4021800,
    32'h9c630001,
    32'he4031000,
    32'h0ffffffd,
    32'h15000000,
    32'h18800000,
    32'h44002000,
    32'h15000000,
    32'h00000000
  };

endpackage

//--- source/wb_round_robin_arbiter.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module wb_round_robin_arbiter (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic [`NUM_MASTERS-1:0] cyc_i,
  output logic [`NUM_MASTERS-1:0] grant_o,
  output logic                    busy_o
);

  localparam int IDX_W = (`NUM_MASTERS > 1) ? $clog2(`NUM_MASTERS) : 1;

  logic                    busy_q;
  logic [`NUM_MASTERS-1:0] owner_q;
  logic [IDX_W-1:0]        last_q;
  logic [`NUM_MASTERS-1:0] next_grant;
  logic [IDX_W-1:0]        next_idx;

  // Nearest requester after the last owner wins
  always_comb begin
    int cand;
    next_grant = '0;
    next_idx   = last_q;
    for (int off = `NUM_MASTERS; off >= 1; off--) begin
      cand = (int'(last_q) + off) % `NUM_MASTERS;
      if (cyc_i[cand]) begin
        next_grant       = '0;
        next_grant[cand] = 1'b1;
        next_idx         = IDX_W'(cand);
      end
    end
  end

  // Idle bus grants in the same cycle
  assign grant_o = busy_q ? owner_q : next_grant;
  assign busy_o  = |grant_o;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
      last_q  <= IDX_W'(`NUM_MASTERS - 1);
    end else if (!busy_q) begin
      if (|cyc_i) begin
        busy_q  <= 1'b1;
        owner_q <= next_grant;
        last_q  <= next_idx;
      end
    end else if (!(|(owner_q & cyc_i))) begin
      busy_q <= 1'b0;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0(grant_o));

endmodule

//--- source/wb_slave_decoder.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module wb_slave_decoder (
  input  logic [`WB_ADR_W-1:0] adr_i,
  input  logic                 we_i,
  output tile_pkg::slave_sel_t sel_o
);

  logic [`REGION_W-1:0] region;

  assign region = adr_i[`WB_ADR_W-1 -: `REGION_W];

  always_comb begin
    case (region)
      `REGION_SRAM: begin
        sel_o = tile_pkg::SLV_SRAM;
      end
      `REGION_EXT: begin
        sel_o = tile_pkg::SLV_EXT;
      end
      `REGION_BOOT: begin
        // ROM is read only, writes end in a bus error
        sel_o = we_i ? tile_pkg::SLV_NONE : tile_pkg::SLV_BOOT;
      end
      default: begin
        sel_o = tile_pkg::SLV_NONE;
      end
    endcase
  end

endmodule

//--- source/wb_shared_bus.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module wb_shared_bus (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  wb_pkg::wb_req_t [`NUM_MASTERS-1:0] m_req_i,
  output wb_pkg::wb_rsp_t [`NUM_MASTERS-1:0] m_rsp_o,
  output wb_pkg::wb_req_t                     sram_req_o,
  input  wb_pkg::wb_rsp_t                     sram_rsp_i,
  output wb_pkg::wb_req_t                     boot_req_o,
  input  wb_pkg::wb_rsp_t                     boot_rsp_i,
  output wb_pkg::wb_req_t                     ext_req_o,
  input  wb_pkg::wb_rsp_t                     ext_rsp_i
);

  logic [`NUM_MASTERS-1:0] cyc;
  logic [`NUM_MASTERS-1:0] grant;
  logic                    busy;
  wb_pkg::wb_req_t         bus_req;
  wb_pkg::wb_rsp_t         bus_rsp;
  tile_pkg::slave_sel_t    sel;
  logic                    nomap_err_q;

  function automatic wb_pkg::wb_req_t route(input wb_pkg::wb_req_t req, input logic hit);
    wb_pkg::wb_req_t r;
    r     = req;
    r.cyc = req.cyc & hit;
    r.stb = req.stb & hit;
    return r;
  endfunction

  always_comb begin
    for (int i = 0; i < `NUM_MASTERS; i++) begin
      cyc[i] = m_req_i[i].cyc;
    end
  end

  wb_round_robin_arbiter u_arb (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cyc_i   (cyc),
    .grant_o (grant),
    .busy_o  (busy)
  );

  // Owner's request, strobes dropped while nobody holds the bus
  always_comb begin
    int owner;
    owner = 0;
    for (int i = 0; i < `NUM_MASTERS; i++) begin
      if (grant[i]) begin
        owner = i;
      end
    end
    bus_req     = m_req_i[owner];
    bus_req.cyc = bus_req.cyc & busy;
    bus_req.stb = bus_req.stb & busy;
  end

  wb_slave_decoder u_dec (
    .adr_i (bus_req.adr),
    .we_i  (bus_req.we),
    .sel_o (sel)
  );

  assign sram_req_o = route(bus_req, sel == tile_pkg::SLV_SRAM);
  assign boot_req_o = route(bus_req, sel == tile_pkg::SLV_BOOT);
  assign ext_req_o  = route(bus_req, sel == tile_pkg::SLV_EXT);

  // Decode error, one pulse per request
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nomap_err_q <= 1'b0;
    end else begin
      nomap_err_q <= bus_req.cyc & bus_req.stb & (sel == tile_pkg::SLV_NONE) & ~nomap_err_q;
    end
  end

  always_comb begin
    bus_rsp = '0;
    case (sel)
      tile_pkg::SLV_SRAM: bus_rsp = sram_rsp_i;
      tile_pkg::SLV_BOOT: bus_rsp = boot_rsp_i;
      tile_pkg::SLV_EXT:  bus_rsp = ext_rsp_i;
      default:            bus_rsp.err = nomap_err_q;
    endcase
  end

  // Only the owner sees the handshake
  always_comb begin
    for (int i = 0; i < `NUM_MASTERS; i++) begin
      m_rsp_o[i].dat = bus_rsp.dat;
      m_rsp_o[i].ack = bus_rsp.ack & grant[i];
      m_rsp_o[i].err = bus_rsp.err & grant[i];
    end
  end

  a_one_slave_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({sram_req_o.stb, boot_req_o.stb, ext_req_o.stb}));

  for (genvar g = 0; g < `NUM_MASTERS; g++) begin : gen_rsp_chk
    a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(m_rsp_o[g].ack && m_rsp_o[g].err));
  end

endmodule

//--- source/wb_sram_slave.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module wb_sram_slave (
  input  logic            clk,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  localparam int OFF_W  = $clog2(`WB_SEL_W);
  localparam int IDX_W  = $clog2(`SRAM_WORDS);
  localparam int BYTE_W = `WB_DAT_W / `WB_SEL_W;

  logic [`WB_DAT_W-1:0] mem [`SRAM_WORDS];
  logic [IDX_W-1:0]     idx;
  logic [`WB_DAT_W-1:0] rdata_q;
  logic                 ack_q;
  logic                 hit;

  // Upper address bits ignored, memory wraps
  assign idx = req_i.adr[OFF_W +: IDX_W];

  // Stb still high in the ack cycle belongs to the finished access
  assign hit = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (hit) begin
      if (req_i.we) begin
        for (int b = 0; b < `WB_SEL_W; b++) begin
          if (req_i.sel[b]) begin
            mem[idx][b*BYTE_W +: BYTE_W] <= req_i.dat[b*BYTE_W +: BYTE_W];
          end
        end
      end
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  always_comb begin
    rsp_o.dat = rdata_q;
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0;
  end

endmodule

//--- source/wb_bootrom.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module wb_bootrom (
  input  logic            clk,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  localparam int OFF_W = $clog2(`WB_SEL_W);
  localparam int IDX_W = $clog2(`BOOT_WORDS);

  logic [IDX_W-1:0]     idx;
  logic [`WB_DAT_W-1:0] rdata_q;
  logic                 ack_q;
  logic                 hit;

  // Image repeats over the whole region
  assign idx = req_i.adr[OFF_W +: IDX_W];
  assign hit = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (hit) begin
      rdata_q <= tile_pkg::BOOT_IMAGE[idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= hit;
    end
  end

  always_comb begin
    rsp_o.dat = rdata_q;
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0;
  end

  // Decoder turns boot writes into decode errors
  a_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_i.cyc && req_i.stb |-> !req_i.we);

endmodule

//--- source/compute_tile.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module compute_tile (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  wb_pkg::wb_req_t [`NUM_MASTERS-1:0] m_req_i,
  output wb_pkg::wb_rsp_t [`NUM_MASTERS-1:0] m_rsp_o,
  output wb_pkg::wb_req_t                     ext_req_o,
  input  wb_pkg::wb_rsp_t                     ext_rsp_i
);

  wb_pkg::wb_req_t sram_req;
  wb_pkg::wb_rsp_t sram_rsp;
  wb_pkg::wb_req_t boot_req;
  wb_pkg::wb_rsp_t boot_rsp;

  wb_shared_bus u_bus (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .m_req_i    (m_req_i),
    .m_rsp_o    (m_rsp_o),
    .sram_req_o (sram_req),
    .sram_rsp_i (sram_rsp),
    .boot_req_o (boot_req),
    .boot_rsp_i (boot_rsp),
    // External memory slave sits directly on the top-level port
    .ext_req_o  (ext_req_o),
    .ext_rsp_i  (ext_rsp_i)
  );

  // Local data memory, region 0x0
  wb_sram_slave u_sram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (sram_req),
    .rsp_o   (sram_rsp)
  );

  wb_bootrom u_bootrom (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .req_i   (boot_req),
    .rsp_o   (boot_rsp)
  );

endmodule

//--- verif/compute_tile_tb.sv
`timescale 1ns/1ps
`include "tile_params.svh"

module compute_tile_tb;

  localparam int RESET_CYCLES   = 5;
  // Three times the length of the tests
  localparam int TIMEOUT_CYCLES = 6000;
  localparam int REF_WORDS      = 32;

  logic                                clk;
  logic                                rst_n_i;
  wb_pkg::wb_req_t [`NUM_MASTERS-1:0] m_req;
  wb_pkg::wb_rsp_t [`NUM_MASTERS-1:0] m_rsp;
  wb_pkg::wb_req_t                     ext_req;
  wb_pkg::wb_rsp_t                     ext_rsp;
  // Expected external request, zero while none may appear
  wb_pkg::wb_req_t                     ext_exp;
  logic                                ext_pending;
  int                                  ext_delay;
  logic                                req_seen;
  int                                  last_owner;
  logic [`WB_DAT_W-1:0]                ref_mem [REF_WORDS];

  compute_tile i_compute_tile (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .m_req_i   (m_req),
    .m_rsp_o   (m_rsp),
    .ext_req_o (ext_req),
    .ext_rsp_i (ext_rsp)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    abort_run($sformatf("Fail at %0d ns: %s expected %0h, got %0h", $time, name, exp, act));
  endtask

  function automatic wb_pkg::wb_req_t make_req(input logic [`WB_ADR_W-1:0] adr,
      input logic [`WB_DAT_W-1:0] dat, input logic [`WB_SEL_W-1:0] sel, input logic we);
    wb_pkg::wb_req_t r;
    r     = '0;
    r.adr = adr;
    r.dat = dat;
    r.sel = sel;
    r.we  = we;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    return r;
  endfunction

  // Random upper bits, the memory wraps on the word index
  function automatic logic [`WB_ADR_W-1:0] sram_addr(input int idx);
    return {`REGION_SRAM, 16'($urandom), 10'(idx), 2'b00};
  endfunction

  function automatic logic [`WB_DAT_W-1:0] merge_lanes(input logic [`WB_DAT_W-1:0] old,
      input logic [`WB_DAT_W-1:0] dat, input logic [`WB_SEL_W-1:0] sel);
    logic [`WB_DAT_W-1:0] r;
    r = old;
    for (int b = 0; b < `WB_SEL_W; b++) begin
      if (sel[b]) begin
        r[b*8 +: 8] = dat[b*8 +: 8];
      end
    end
    return r;
  endfunction

  // One classic transfer, lat counts cycles from the request to ack or err
  task automatic transfer(input int m, input wb_pkg::wb_req_t req,
      output wb_pkg::wb_rsp_t rsp, output int lat);
    @(negedge clk);
    m_req[m] = req;
    req_seen = 1'b1;
    rsp      = '0;
    lat      = -1;
    while (!(rsp.ack || rsp.err)) begin
      @(posedge clk);
      lat++;
      rsp = m_rsp[m];
    end
    last_owner = m;
    @(negedge clk);
    m_req[m] = '0;
  endtask

  task automatic check_rsp(input int m, input wb_pkg::wb_rsp_t rsp, input int lat,
      input logic exp_ack);
    assert ({rsp.ack, rsp.err} == {exp_ack, !exp_ack})
      else fail_value($sformatf("m_rsp_o[%0d] ack,err", m), {exp_ack, !exp_ack},
        {rsp.ack, rsp.err});
    assert (lat == 1) else fail_value($sformatf("m_rsp_o[%0d] latency", m), 1, lat);
  endtask

  task automatic sram_write(input int m, input int idx, input logic [`WB_DAT_W-1:0] dat,
      input logic [`WB_SEL_W-1:0] sel);
    wb_pkg::wb_rsp_t rsp;
    int              lat;
    transfer(m, make_req(sram_addr(idx), dat, sel, 1'b1), rsp, lat);
    check_rsp(m, rsp, lat, 1'b1);
    ref_mem[idx] = merge_lanes(ref_mem[idx], dat, sel);
  endtask

  task automatic sram_read(input int m, input int idx);
    wb_pkg::wb_rsp_t rsp;
    int              lat;
    transfer(m, make_req(sram_addr(idx), $urandom, 4'hf, 1'b0), rsp, lat);
    check_rsp(m, rsp, lat, 1'b1);
    assert (rsp.dat == ref_mem[idx])
      else fail_value($sformatf("m_rsp_o[%0d].dat", m), ref_mem[idx], rsp.dat);
  endtask

  // Both masters hit the SRAM in the same cycle on an idle bus
  // A lone access by lead first makes the other master next in turn
  task automatic arb_round(input logic we, input int lead);
    wb_pkg::wb_req_t req [2];
    wb_pkg::wb_rsp_t rsp [2];
    int              lat [2];
    int              idx [2];
    int              first;
    sram_read(lead, int'($urandom % REF_WORDS));
    idx[0] = 2 * int'($urandom % (REF_WORDS / 2));
    idx[1] = idx[0] + 1;
    for (int k = 0; k < 2; k++) begin
      req[k] = make_req(sram_addr(idx[k]), $urandom, we ? 4'($urandom) : 4'hf, we);
    end
    first = (last_owner + 1) % `NUM_MASTERS;
    fork
      transfer(0, req[0], rsp[0], lat[0]);
      transfer(1, req[1], rsp[1], lat[1]);
    join
    assert (lat[first] == 1)
      else fail_value($sformatf("m_rsp_o[%0d] latency", first), 1, lat[first]);
    assert (lat[1-first] > lat[first])
      else abort_run($sformatf("Fail at %0d ns: master %0d was served before master %0d",
        $time, 1 - first, first));
    for (int k = 0; k < 2; k++) begin
      assert (rsp[k].ack && !rsp[k].err)
        else fail_value($sformatf("m_rsp_o[%0d] ack,err", k), 2'b10, {rsp[k].ack, rsp[k].err});
      if (we) begin
        ref_mem[idx[k]] = merge_lanes(ref_mem[idx[k]], req[k].dat, req[k].sel);
      end else begin
        assert (rsp[k].dat == ref_mem[idx[k]])
          else fail_value($sformatf("m_rsp_o[%0d].dat", k), ref_mem[idx[k]], rsp[k].dat);
      end
    end
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // External memory, read data is the inverted address
  initial begin : ext_slave_model
    logic [`WB_ADR_W-1:0] adr;
    ext_rsp     = '0;
    ext_pending = 1'b0;
    ext_delay   = 0;
    forever begin
      @(posedge clk);
      if (rst_n_i && ext_req.cyc && ext_req.stb) begin
        ext_pending = 1'b1;
        ext_delay   = 1 + int'($urandom % 4);
        adr         = ext_req.adr;
        repeat (ext_delay - 1) @(posedge clk);
        @(negedge clk);
        ext_pending = 1'b0;
        ext_rsp.dat = ~adr;
        ext_rsp.ack = 1'b1;
        @(negedge clk);
        ext_rsp = '0;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    abort_run($sformatf("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES));
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n_i)
    !req_seen |-> !(m_rsp[0].ack || m_rsp[0].err || m_rsp[1].ack || m_rsp[1].err ||
      ext_req.cyc || ext_req.stb))
    else fail_value("m_rsp_o ack,err and ext_req_o cyc,stb", 0,
      $sampled({m_rsp[0].ack, m_rsp[0].err, m_rsp[1].ack, m_rsp[1].err,
        ext_req.cyc, ext_req.stb}));

  a_ext_fields: assert property (@(posedge clk) disable iff (!rst_n_i)
    ext_req.stb |-> ext_req == ext_exp)
    else fail_value("ext_req_o", $sampled(ext_exp), $sampled(ext_req));

  a_ext_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    ext_pending |-> ext_req.cyc && ext_req.stb)
    else abort_run($sformatf("Fail at %0d ns: request dropped before the external ack", $time));

  a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n_i)
    !((m_rsp[0].ack || m_rsp[0].err) && (m_rsp[1].ack || m_rsp[1].err)))
    else abort_run($sformatf("Fail at %0d ns: both masters got a response", $time));

  for (genvar g = 0; g < `NUM_MASTERS; g++) begin : gen_owner_chk
    a_rsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
      (m_rsp[g].ack || m_rsp[g].err) |-> m_req[g].cyc && m_req[g].stb)
      else abort_run($sformatf("Fail at %0d ns: master %0d answered without a request",
        $time, g));
  end

  initial begin : stimulus
    wb_pkg::wb_req_t      req;
    wb_pkg::wb_rsp_t      rsp;
    int                   lat;
    int                   m;
    logic [`WB_ADR_W-1:0] adr;
    void'($urandom(72));
    rst_n_i    = 1'b0;
    m_req      = '0;
    ext_exp    = '0;
    req_seen   = 1'b0;
    last_owner = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    repeat (4) @(negedge clk);

    for (int i = 0; i < REF_WORDS; i++) begin
      sram_write(int'($urandom % `NUM_MASTERS), i, $urandom, 4'hf);
    end
    // Lane writes, each followed by a read somewhere
    for (int i = 0; i < 200; i++) begin
      sram_write(int'($urandom % `NUM_MASTERS), int'($urandom % REF_WORDS), $urandom,
        4'($urandom));
      sram_read(int'($urandom % `NUM_MASTERS), int'($urandom % REF_WORDS));
    end

    for (int i = 0; i < 20; i++) begin
      m   = int'($urandom % `NUM_MASTERS);
      adr = {`REGION_BOOT, 26'($urandom), 2'b00};
      transfer(m, make_req(adr, $urandom, 4'hf, 1'b0), rsp, lat);
      check_rsp(m, rsp, lat, 1'b1);
      assert (rsp.dat == tile_pkg::BOOT_IMAGE[(adr >> 2) % `BOOT_WORDS])
        else fail_value("m_rsp_o.dat", tile_pkg::BOOT_IMAGE[(adr >> 2) % `BOOT_WORDS], rsp.dat);
    end
    for (int i = 0; i < 5; i++) begin
      m = int'($urandom % `NUM_MASTERS);
      transfer(m, make_req({`REGION_BOOT, 28'($urandom)}, $urandom, 4'($urandom), 1'b1),
        rsp, lat);
      check_rsp(m, rsp, lat, 1'b0);
    end

    // Unmapped regions 0x1 to 0xd
    for (int i = 0; i < 10; i++) begin
      m   = int'($urandom % `NUM_MASTERS);
      adr = {4'(1 + $urandom % 13), 28'($urandom)};
      transfer(m, make_req(adr, $urandom, 4'($urandom), 1'($urandom)), rsp, lat);
      check_rsp(m, rsp, lat, 1'b0);
    end

    for (int i = 0; i < 40; i++) begin
      m       = int'($urandom % `NUM_MASTERS);
      req     = make_req({`REGION_EXT, 28'($urandom)}, $urandom, 4'($urandom), 1'($urandom));
      ext_exp = req;
      transfer(m, req, rsp, lat);
      ext_exp = '0;
      assert (rsp.ack && !rsp.err)
        else fail_value("m_rsp_o ack,err", 2'b10, {rsp.ack, rsp.err});
      assert (lat == ext_delay) else fail_value("m_rsp_o latency", ext_delay, lat);
      if (!req.we) begin
        assert (rsp.dat == ~req.adr) else fail_value("m_rsp_o.dat", ~req.adr, rsp.dat);
      end
    end

    // Both masters take turns as the first one served
    for (int r = 0; r < 20; r++) begin
      arb_round(r % 2 == 0, (r / 2) % `NUM_MASTERS);
    end

    repeat (4) @(negedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+source
source/wb_pkg.sv
source/tile_pkg.sv
source/wb_round_robin_arbiter.sv
source/wb_slave_decoder.sv
source/wb_shared_bus.sv
source/wb_sram_slave.sv
source/wb_bootrom.sv
source/compute_tile.sv
verif/compute_tile_tb.sv
